// File: logic/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  alu_ctl_t ctl,
    input  word_t    a,
    input  word_t    b,
    input  funct3_t  funct3,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    output word_t    result,
    output logic     br_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (ctl)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   result = {31'b0, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    // branch compare works on the register values, not the operand muxes.
    always_comb begin
        case (funct3)
            fnc_beq:  br_taken = (rs1_val == rs2_val);
            fnc_bne:  br_taken = (rs1_val != rs2_val);
            fnc_blt:  br_taken = ($signed(rs1_val) < $signed(rs2_val));
            fnc_bge:  br_taken = ($signed(rs1_val) >= $signed(rs2_val));
            fnc_bltu: br_taken = (rs1_val < rs2_val);
            fnc_bgeu: br_taken = (rs1_val >= rs2_val);
            default:  br_taken = 1'b0;
        endcase
    end

endmodule

// File: logic/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       cyc,
    output logic       stb,
    output logic       we,
    output word_t      adr,
    output word_t      dat_w,
    output logic [3:0] sel,
    input  word_t      dat_r,
    input  logic       ack,
    output word_t      inst,
    output word_t      pc,
    input  logic       reg_write,
    input  logic [1:0] wb_sel,
    input  logic       jump,
    input  logic       jop,
    input  logic       branch,
    input  logic       mem_read,
    input  logic       mem_write,
    input  word_t      alu_result,
    input  logic       br_taken,
    input  word_t      rs2_val,
    input  word_t      imm,
    output logic       rf_we,
    output word_t      rf_wd
);

    seq_state_t state;
    word_t      load_data;
    word_t      pc_plus4;
    word_t      br_target;
    word_t      next_pc;

    assign sel       = 4'hf;
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + imm;

    always_comb begin
        if (jump) begin
            next_pc = jop ? {alu_result[31:1], 1'b0} : alu_result;
        end else if (branch && br_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (wb_sel)
            wb_mem:  rf_wd = load_data;
            wb_pc4:  rf_wd = pc_plus4;
            default: rf_wd = alu_result;
        endcase
    end

    assign rf_we = (state == s_wb) && reg_write;

    // ##############################
    // sequencer and bus cycles
    // ##############################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_fetch;
            pc    <= reset_pc;
            cyc   <= 1'b0;
            stb   <= 1'b0;
            we    <= 1'b0;
        end else begin
            case (state)
                s_fetch: begin
                    if (!cyc) begin
                        // only the first fetch after reset starts here.
                        cyc <= 1'b1;
                        stb <= 1'b1;
                        we  <= 1'b0;
                        adr <= pc;
                    end else if (ack) begin
                        inst  <= dat_r;
                        cyc   <= 1'b0;
                        stb   <= 1'b0;
                        state <= s_exec;
                    end
                end
                s_exec: begin
                    if (mem_read || mem_write) begin
                        cyc   <= 1'b1;
                        stb   <= 1'b1;
                        we    <= mem_write;
                        adr   <= alu_result;
                        dat_w <= rs2_val;
                        state <= s_mem;
                    end else begin
                        state <= s_wb;
                    end
                end
                s_mem: begin
                    if (ack) begin
                        load_data <= dat_r;
                        cyc       <= 1'b0;
                        stb       <= 1'b0;
                        we        <= 1'b0;
                        state     <= s_wb;
                    end
                end
                default: begin
                    // launch the next fetch right away.
                    pc    <= next_pc;
                    adr   <= next_pc;
                    cyc   <= 1'b1;
                    stb   <= 1'b1;
                    we    <= 1'b0;
                    state <= s_fetch;
                end
            endcase
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) stb |-> cyc);

    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (stb && !ack) |=> $stable(adr));

endmodule

// File: logic/control_path.sv
`timescale 1ns/1ps

module control_path import rv_pkg::*; (
    input  opcode_t    opcode,
    input  funct3_t    funct3,
    input  logic       inst_bit30,
    output logic       reg_write,
    output logic       b_sel_rs2,
    output logic [1:0] opa_sel,
    output logic [1:0] wb_sel,
    output logic       jump,
    output logic       branch,
    output logic       jop,
    output logic       mem_read,
    output logic       mem_write,
    output alu_ctl_t   alu_ctl
);

    logic alu_op;

    always_comb begin
        // unknown opcodes fall through as a no-op.
        reg_write = 1'b0;
        b_sel_rs2 = 1'b0;
        opa_sel   = opa_rs1;
        wb_sel    = wb_alu;
        jump      = 1'b0;
        branch    = 1'b0;
        jop       = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_ctl   = alu_add;
        alu_op    = 1'b0;

        case (opcode)
            opc_lui: begin
                reg_write = 1'b1;
                opa_sel   = opa_zero;
                alu_ctl   = alu_pass_b;
            end
            opc_auipc: begin
                reg_write = 1'b1;
                opa_sel   = opa_pc;
            end
            opc_jal: begin
                reg_write = 1'b1;
                opa_sel   = opa_pc;
                wb_sel    = wb_pc4;
                jump      = 1'b1;
            end
            opc_jalr: begin
                reg_write = 1'b1;
                wb_sel    = wb_pc4;
                jump      = 1'b1;
                jop       = 1'b1;
            end
            opc_branch: branch = 1'b1;
            opc_load: begin
                reg_write = 1'b1;
                wb_sel    = wb_mem;
                mem_read  = 1'b1;
            end
            opc_store: mem_write = 1'b1;
            opc_ari_rtype: begin
                reg_write = 1'b1;
                b_sel_rs2 = 1'b1;
                alu_op    = 1'b1;
            end
            opc_ari_itype: begin
                reg_write = 1'b1;
                alu_op    = 1'b1;
            end
            default: ;
        endcase

        if (alu_op) begin
            case (funct3)
                // sub exists only in the register form.
                fnc_add_sub: alu_ctl = (inst_bit30 && b_sel_rs2) ? alu_sub : alu_add;
                fnc_sll:     alu_ctl = alu_sll;
                fnc_slt:     alu_ctl = alu_slt;
                fnc_sltu:    alu_ctl = alu_sltu;
                fnc_xor:     alu_ctl = alu_xor;
                fnc_srl_sra: alu_ctl = inst_bit30 ? alu_sra : alu_srl;
                fnc_or:      alu_ctl = alu_or;
                default:     alu_ctl = alu_and;
            endcase
        end
    end

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t inst,
    output word_t imm
);

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            opc_jalr, opc_load, opc_ari_itype:
                imm = {{20{inst[31]}}, inst[31:20]};
            opc_store:
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opc_branch:
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {inst[31:12], 12'b0};
            opc_jal:
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            // register ops carry no immediate.
            default:
                imm = '0;
        endcase
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    // x0 is cleared in reset and never written.
    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs[0] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // a read of x0 returns zero on either port.
    a_x0_rd1: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (rd1 == '0));

    a_x0_rd2: assert property (@(posedge clk) disable iff (!rst_n)
        (rs2 == '0) |-> (rd2 == '0));

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       cyc,
    output logic       stb,
    output logic       we,
    output word_t      adr,
    output word_t      dat_w,
    output logic [3:0] sel,
    input  word_t      dat_r,
    input  logic       ack
);

    word_t      inst;
    word_t      pc;
    word_t      imm;
    word_t      rd1;
    word_t      rd2;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_result;
    word_t      rf_wd;
    logic       rf_we;
    logic       br_taken;
    logic       reg_write;
    logic       b_sel_rs2;
    logic [1:0] opa_sel;
    logic [1:0] wb_sel;
    logic       jump;
    logic       branch;
    logic       jop;
    logic       mem_read;
    logic       mem_write;
    alu_ctl_t   alu_ctl;

    // operand muxes.
    assign op_a = (opa_sel == opa_pc)   ? pc :
                  (opa_sel == opa_zero) ? '0 : rd1;
    assign op_b = b_sel_rs2 ? rd2 : imm;

    control_path control_path_i (
        .opcode(inst[6:0]), .funct3(inst[14:12]), .inst_bit30(inst[30]),
        .reg_write(reg_write), .b_sel_rs2(b_sel_rs2), .opa_sel(opa_sel),
        .wb_sel(wb_sel), .jump(jump), .branch(branch), .jop(jop),
        .mem_read(mem_read), .mem_write(mem_write), .alu_ctl(alu_ctl)
    );

    imm_gen imm_gen_i (.inst(inst), .imm(imm));

    alu alu_i (
        .ctl(alu_ctl), .a(op_a), .b(op_b), .funct3(inst[14:12]),
        .rs1_val(rd1), .rs2_val(rd2), .result(alu_result), .br_taken(br_taken)
    );

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n),
        .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(inst[11:7]),
        .we(rf_we), .wd(rf_wd), .rd1(rd1), .rd2(rd2)
    );

    bus_sequencer bus_sequencer_i (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
        .dat_r(dat_r), .ack(ack), .inst(inst), .pc(pc),
        .reg_write(reg_write), .wb_sel(wb_sel), .jump(jump), .jop(jop),
        .branch(branch), .mem_read(mem_read), .mem_write(mem_write),
        .alu_result(alu_result), .br_taken(br_taken), .rs2_val(rd2), .imm(imm),
        .rf_we(rf_we), .rf_wd(rf_wd)
    );

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // ##############################
    // widths
    // ##############################
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_ctl_t;

    // ##############################
    // opcodes
    // ##############################
    localparam opcode_t opc_lui       = 7'b0110111;
    localparam opcode_t opc_auipc     = 7'b0010111;
    localparam opcode_t opc_jal       = 7'b1101111;
    localparam opcode_t opc_jalr      = 7'b1100111;
    localparam opcode_t opc_branch    = 7'b1100011;
    localparam opcode_t opc_load      = 7'b0000011;
    localparam opcode_t opc_store     = 7'b0100011;
    localparam opcode_t opc_ari_rtype = 7'b0110011;
    localparam opcode_t opc_ari_itype = 7'b0010011;

    // alu funct3 codes.
    localparam funct3_t fnc_add_sub = 3'b000;
    localparam funct3_t fnc_sll     = 3'b001;
    localparam funct3_t fnc_slt     = 3'b010;
    localparam funct3_t fnc_sltu    = 3'b011;
    localparam funct3_t fnc_xor     = 3'b100;
    localparam funct3_t fnc_srl_sra = 3'b101;
    localparam funct3_t fnc_or      = 3'b110;
    localparam funct3_t fnc_and     = 3'b111;

    // branch funct3 codes.
    localparam funct3_t fnc_beq  = 3'b000;
    localparam funct3_t fnc_bne  = 3'b001;
    localparam funct3_t fnc_blt  = 3'b100;
    localparam funct3_t fnc_bge  = 3'b101;
    localparam funct3_t fnc_bltu = 3'b110;
    localparam funct3_t fnc_bgeu = 3'b111;

    localparam alu_ctl_t alu_add    = 4'd0;
    localparam alu_ctl_t alu_sub    = 4'd1;
    localparam alu_ctl_t alu_sll    = 4'd2;
    localparam alu_ctl_t alu_slt    = 4'd3;
    localparam alu_ctl_t alu_sltu   = 4'd4;
    localparam alu_ctl_t alu_xor    = 4'd5;
    localparam alu_ctl_t alu_srl    = 4'd6;
    localparam alu_ctl_t alu_sra    = 4'd7;
    localparam alu_ctl_t alu_or     = 4'd8;
    localparam alu_ctl_t alu_and    = 4'd9;
    localparam alu_ctl_t alu_pass_b = 4'd10;

    // operand a select.
    localparam logic [1:0] opa_rs1  = 2'd0;
    localparam logic [1:0] opa_pc   = 2'd1;
    localparam logic [1:0] opa_zero = 2'd2;

    // write-back select.
    localparam logic [1:0] wb_alu = 2'd0;
    localparam logic [1:0] wb_mem = 2'd1;
    localparam logic [1:0] wb_pc4 = 2'd2;

    typedef enum logic [1:0] {
        s_fetch,
        s_exec,
        s_mem,
        s_wb
    } seq_state_t;

    localparam word_t reset_pc = 32'h0000_0000;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rv_core.f --top-module tb_rv_core -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: rv_core.f
logic/rv_pkg.sv
logic/control_path.sv
logic/imm_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/bus_sequencer.sv
logic/rv_core.sv
tb/wb_memory.sv
tb/tb_rv_core.sv

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    localparam int clk_period   = 20;
    localparam int alu_insts    = 50;
    localparam int upper_insts  = 10;
    localparam int branch_insts = 150;
    localparam int jump_insts   = 20;
    localparam int mem_insts    = 20;
    localparam int watchdog_cycles =
        (alu_insts + upper_insts + branch_insts + jump_insts + mem_insts) * 10 + 500;
    localparam logic [11:0] base_adr = 12'h600;
    localparam logic [9:0]  base_idx = base_adr[11:2];

    logic       clk;
    logic       rst_n;
    logic       cyc;
    logic       stb;
    logic       we;
    logic       ack;
    logic [3:0] sel;
    word_t      adr;
    word_t      dat_w;
    word_t      dat_r;

    int    ptr;
    int    pass_count;
    int    fail_count;
    int    test_errors;
    int    bus_errors;
    word_t exp_q [$];
    string name_q [$];

    logic  hold_prev = 1'b0;
    logic  prev_rst  = 1'b1;
    logic  prev_we;
    word_t prev_adr;
    word_t prev_dat_w;

    rv_core rv_core_i (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
    );

    wb_memory mem_i (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: the tests did not reach their halt address in time");
        $display("RESULT: FAIL");
        $finish;
    end

    // ##############################
    // bus monitor
    // ##############################
    always @(posedge clk) begin
        if (hold_prev && (adr !== prev_adr || we !== prev_we || dat_w !== prev_dat_w)) begin
            $display("bus monitor: adr, we or dat_w changed before ack at %0t", $time);
            bus_errors++;
        end
        if (rst_n === 1'b0 && !prev_rst && cyc !== 1'b0) begin
            $display("bus monitor: a bus cycle started while reset was held at %0t", $time);
            bus_errors++;
        end
        if (rst_n === 1'b1 && stb === 1'b1 && sel !== 4'hf) begin
            $display("** Error: sel: expected %h, got %h at %0t", 4'hf, sel, $time);
            bus_errors++;
        end
        hold_prev  = (rst_n === 1'b1) && (stb === 1'b1) && (ack === 1'b0);
        prev_rst   = rst_n;
        prev_adr   = adr;
        prev_we    = we;
        prev_dat_w = dat_w;
    end

    // ##############################
    // instruction encoding
    // ##############################
    function automatic word_t rtype(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_ari_rtype};
    endfunction

    function automatic word_t itype(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                    reg_addr_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t stype(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3, opcode_t opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic word_t btype(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t utype(logic [19:0] imm, reg_addr_t rd, opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t jtype(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    function automatic word_t fill_word(logic [9:0] idx);
        return {6'h2b, idx, 6'h15, idx};
    endfunction

    // RV32I results, keyed by funct3 and the alternate bit.
    function automatic word_t alu_model(funct3_t f, logic alt, word_t a, word_t b);
        case (f)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(funct3_t f, word_t a, word_t b);
        case (f)
            fnc_beq:  return a == b;
            fnc_bne:  return a != b;
            fnc_blt:  return $signed(a) < $signed(b);
            fnc_bge:  return $signed(a) >= $signed(b);
            fnc_bltu: return a < b;
            default:  return a >= b;
        endcase
    endfunction

    // ##############################
    // program building and checking
    // ##############################
    task automatic emit(word_t inst);
        mem_i.write_word(10'(ptr), inst);
        ptr++;
    endtask

    task automatic addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        emit(itype(imm, rs1, fnc_add_sub, rd, opc_ari_itype));
    endtask

    task automatic load_const(reg_addr_t rd, word_t value);
        word_t upper;
        upper = value + 32'h800;
        emit(utype(upper[31:12], rd, opc_lui));
        addi(rd, rd, value[11:0]);
    endtask

    // each stored result gets the next word above the data base.
    task automatic store_expect(reg_addr_t rs, string name, word_t value);
        emit(stype(12'(exp_q.size() * 4), rs, 10, 3'b010, opc_store));
        exp_q.push_back(value);
        name_q.push_back(name);
    endtask

    task automatic expect_untouched(string name);
        exp_q.push_back(fill_word(10'(base_idx + exp_q.size())));
        name_q.push_back(name);
    endtask

    task automatic start_program();
        int k;
        @(negedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        for (k = 0; k < 1024; k++) begin
            mem_i.write_word(10'(k), fill_word(10'(k)));
        end
        ptr = 0;
        exp_q.delete();
        name_q.delete();
        addi(10, 0, base_adr);
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_program(string name);
        word_t      halt_adr;
        word_t      got;
        logic [9:0] idx;
        int         k;
        halt_adr = word_t'(ptr * 4);
        emit(jtype(21'd0, 0));
        @(negedge clk);
        rst_n <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(stb === 1'b1 && we === 1'b0 && adr === halt_adr));
        @(negedge clk);
        for (k = 0; k < exp_q.size(); k++) begin
            idx = 10'(base_idx + k);
            got = mem_i.read_word(idx);
            if (got !== exp_q[k]) begin
                $display("** Error: %s (mem word %03h): expected %08h, got %08h",
                         name_q[k], idx, exp_q[k], got);
                test_errors++;
            end
        end
        finish_test(name);
    endtask

    // ##############################
    // directed tests
    // ##############################
    task automatic test_alu();
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        int          f;
        int          alt;
        a = 32'h8765_4321;
        b = 32'h0f0f_1235;
        start_program();
        load_const(1, a);
        load_const(2, b);
        for (f = 0; f < 8; f++) begin
            for (alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    emit(rtype(alt ? 7'h20 : 7'h00, 2, 1, 3'(f), 3));
                    store_expect(3, $sformatf("reg op f3=%0d alt=%0d", f, alt),
                                 alu_model(3'(f), alt[0], a, b));
                end
                if (alt == 0 || f == 5) begin
                    // shift immediates carry the shift amount in imm[4:0].
                    imm = (f == 1 || f == 5) ? {(alt ? 7'h20 : 7'h00), 5'd7} : 12'hcab;
                    emit(itype(imm, 1, 3'(f), 3, opc_ari_itype));
                    store_expect(3, $sformatf("imm op f3=%0d alt=%0d", f, alt),
                                 alu_model(3'(f), alt[0], a, {{20{imm[11]}}, imm}));
                end
            end
        end
        run_program("alu operations");
    endtask

    task automatic test_upper();
        word_t at;
        start_program();
        emit(utype(20'habcde, 3, opc_lui));
        store_expect(3, "lui value", 32'habcd_e000);
        at = word_t'(ptr * 4);
        emit(utype(20'h12345, 4, opc_auipc));
        store_expect(4, "auipc value", 32'h1234_5000 + at);
        at = word_t'(ptr * 4);
        emit(utype(20'hfffff, 5, opc_auipc));
        store_expect(5, "auipc negative value", 32'hffff_f000 + at);
        run_program("lui and auipc");
    endtask

    task automatic test_branches();
        word_t   lhs [3];
        word_t   rhs [3];
        funct3_t kinds [6];
        string   names [6];
        int      t;
        int      p;
        lhs   = '{32'd5, 32'hffff_fffd, 32'd2};
        rhs   = '{32'd5, 32'd2, 32'hffff_fffd};
        kinds = '{fnc_beq, fnc_bne, fnc_blt, fnc_bge, fnc_bltu, fnc_bgeu};
        names = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        start_program();
        for (t = 0; t < 6; t++) begin
            for (p = 0; p < 3; p++) begin
                load_const(1, lhs[p]);
                load_const(2, rhs[p]);
                // 0x11 marks the target path, 0x22 the fall-through path.
                addi(5, 0, 12'h011);
                emit(btype(13'd8, 2, 1, kinds[t]));
                addi(5, 0, 12'h022);
                store_expect(5, $sformatf("%s marker, pair %0d", names[t], p),
                             branch_model(kinds[t], lhs[p], rhs[p]) ? 32'h11 : 32'h22);
            end
        end
        run_program("branches");
    endtask

    task automatic test_jumps();
        word_t at;
        word_t target;
        start_program();
        addi(6, 0, 12'h011);
        at = word_t'(ptr * 4);
        emit(jtype(21'd12, 1));
        addi(6, 0, 12'h066);
        addi(6, 0, 12'h066);
        store_expect(1, "jal link", at + 32'd4);
        store_expect(6, "jal skip marker", 32'h11);
        // jalr sits after the two words of load_const.
        at     = word_t'((ptr + 2) * 4);
        target = at + 32'd8;
        load_const(7, target + 32'd1);
        emit(itype(12'd0, 7, 3'b000, 8, opc_jalr));
        addi(6, 0, 12'h077);
        store_expect(8, "jalr link", at + 32'd4);
        store_expect(6, "jalr skip marker", 32'h11);
        run_program("jal and jalr");
    endtask

    task automatic test_memory();
        int slot;
        start_program();
        load_const(1, 32'hcafe_f00d);
        slot = exp_q.size();
        store_expect(1, "sw word", 32'hcafe_f00d);
        emit(itype(12'(slot * 4), 10, 3'b010, 2, opc_load));
        store_expect(2, "lw result", 32'hcafe_f00d);
        addi(0, 0, 12'h055);
        store_expect(0, "x0 after write", 32'h0);
        addi(3, 0, 12'h033);
        slot = exp_q.size();
        expect_untouched("word under unknown store");
        // store-like and addiw-like words that this core does not decode.
        emit(stype(12'(slot * 4), 3, 10, 3'b010, 7'b0100111));
        emit(itype(12'h001, 3, 3'b000, 3, 7'b0011011));
        store_expect(3, "x3 after unknown opcodes", 32'h33);
        run_program("memory and x0");
    endtask

    initial begin
        rst_n <= 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        bus_errors  = 0;
        test_alu();
        test_upper();
        test_branches();
        test_jumps();
        test_memory();
        test_errors = bus_errors;
        finish_test("bus protocol");
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/wb_memory.sv
`timescale 1ns/1ps

module wb_memory import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  word_t      adr,
    input  word_t      dat_w,
    input  logic [3:0] sel,
    output word_t      dat_r,
    output logic       ack
);

    word_t       mem [1024];
    word_t       dat_q   = '0;
    logic        ack_q   = 1'b0;
    logic [31:0] rnd     = 32'h8486_258c;
    logic        pending = 1'b0;
    logic [1:0]  left    = '0;

    assign dat_r = dat_q;
    assign ack   = ack_q;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic write_word(logic [9:0] idx, word_t value);
        mem[idx] = value;
    endtask

    function automatic word_t read_word(logic [9:0] idx);
        return mem[idx];
    endfunction

    // ack follows stb after 0 to 3 falling edges.
    always @(negedge clk) begin
        ack_q <= 1'b0;
        if (!rst_n) begin
            pending = 1'b0;
        end else if (cyc && stb && !ack_q) begin
            if (!pending) begin
                rnd     = xorshift(rnd);
                left    = rnd[1:0];
                pending = 1'b1;
            end
            if (left == 2'd0) begin
                pending = 1'b0;
                ack_q  <= 1'b1;
                // writes honor the byte lanes in sel.
                if (we) begin
                    for (int i = 0; i < 4; i++) begin
                        if (sel[i]) begin
                            mem[adr[11:2]][8*i +: 8] = dat_w[8*i +: 8];
                        end
                    end
                end else begin
                    dat_q <= mem[adr[11:2]];
                end
            end else begin
                left = left - 2'd1;
            end
        end
    end

endmodule
